// ==== common/gemm_defines.svh ====
// tile geometry and element widths of the w4a8 gemm core
// included by the package and by modules that size loops or slices
`ifndef GEMM_DEFINES_SVH
`define GEMM_DEFINES_SVH

// tile shape, C[m][n] = sum over k of A[m][k] * B[n][k]
`define GEMM_M 2
`define GEMM_N 2
`define GEMM_K 4

// element widths
`define A_WIDTH   8
`define B_WIDTH   4
`define RES_WIDTH 32

// input channel
`define BEAT_WIDTH 32
`define A_BEATS    2
`define B_BEATS    1

`endif

// ==== common/gemm_pkg.sv ====
// shared types of the gemm core: beats, packed tiles and the controller states
// compile before any module of the design
`default_nettype none

`include "gemm_defines.svh"

package gemm_pkg;

  typedef logic [`BEAT_WIDTH-1:0] beat_t;

  // row m in beat m, k0 in the low byte
  typedef logic [`GEMM_M*`GEMM_K*`A_WIDTH-1:0] a_tile_t;

  // weight B[n][k] in nibble n*K+k
  typedef logic [`GEMM_N*`GEMM_K*`B_WIDTH-1:0] b_tile_t;

  typedef logic signed [`RES_WIDTH-1:0] res_t;

  // element m*N+n, element 0 at the low end
  typedef logic [`GEMM_M*`GEMM_N*`RES_WIDTH-1:0] res_tile_t;

  typedef struct packed {
    a_tile_t a;
    b_tile_t b;
  } operand_t;

  typedef enum logic [2:0] {IDLE, LOAD, COMPUTE, DRAIN, DONE} ctrl_state_t;

endpackage

`default_nettype wire

// ==== loader/tile_loader.sv ====
// four-phase req/ack receiver that packs BEATS input beats into one tile
// beat 0 lands in the low slot; full holds until clear
`timescale 1ns/1ps
`default_nettype none

module tile_loader #(
  parameter int BEATS = 1
) (
  input  wire                         ap_clk,
  input  wire                         areset,
  input  wire                         load_en,
  input  wire                         clear,
  input  wire                         req,
  input  wire gemm_pkg::beat_t        data,
  output logic                        ack,
  output logic                        full,
  output gemm_pkg::beat_t [BEATS-1:0] tile
);

  localparam int               CNT_W    = $clog2(BEATS + 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(BEATS);

  logic [CNT_W-1:0] cnt;
  logic             take;

  // accept a beat only in the load phase and while slots remain
  assign take = req && !ack && load_en && !full && (cnt != CNT_FULL);

  //////////////////////
  // handshake and beat count
  //////////////////////
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      ack  <= 1'b0;
      full <= 1'b0;
      cnt  <= '0;
    end else begin
      if (take) begin
        ack <= 1'b1;
        cnt <= cnt + 1'b1;
      end else if (ack && !req) begin
        ack <= 1'b0;
        // last beat done once its ack has dropped
        if (cnt == CNT_FULL) begin
          full <= 1'b1;
        end
      end
      if (clear) begin
        full <= 1'b0;
        cnt  <= '0;
      end
    end
  end

  //////////////////////
  // tile storage
  //////////////////////
  always_ff @(posedge ap_clk) begin
    if (take) begin
      tile[cnt] <= data;
    end
  end

endmodule

`default_nettype wire

// ==== core/tile_mac.sv ====
// sequential signed MAC over K for the whole output tile
// res_valid pulses K+1 cycles after mac_start, res holds until the next start
`timescale 1ns/1ps
`default_nettype none

`include "gemm_defines.svh"

module tile_mac (
  input  wire                      ap_clk,
  input  wire                      areset,
  input  wire                      mac_start,
  input  wire gemm_pkg::operand_t  operands,
  output logic                     res_valid,
  output gemm_pkg::res_tile_t      res
);
  import gemm_pkg::*;

  localparam int             ELEMS  = `GEMM_M * `GEMM_N;
  localparam int             K_W    = $clog2(`GEMM_K);
  localparam logic [K_W-1:0] K_LAST = K_W'(`GEMM_K - 1);

  logic           busy;
  logic [K_W-1:0] k_cnt;
  res_t           acc  [ELEMS];
  res_t           term [ELEMS];

  // A[m][k] * B[n][k], both sign-extended to the result width
  function automatic res_t mac_term(input operand_t op, input int m, input int n,
                                    input logic [K_W-1:0] k);
    logic signed [`A_WIDTH-1:0] a_el;
    logic signed [`B_WIDTH-1:0] b_el;
    res_t                       a_ext;
    res_t                       b_ext;
    a_el  = op.a[(m * `GEMM_K + k) * `A_WIDTH +: `A_WIDTH];
    b_el  = op.b[(n * `GEMM_K + k) * `B_WIDTH +: `B_WIDTH];
    a_ext = a_el;
    b_ext = b_el;
    return a_ext * b_ext;
  endfunction

  always_comb begin
    for (int m = 0; m < `GEMM_M; m++) begin
      for (int n = 0; n < `GEMM_N; n++) begin
        term[m * `GEMM_N + n] = mac_term(operands, m, n, k_cnt);
      end
    end
  end

  // k sequencing
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      busy      <= 1'b0;
      k_cnt     <= '0;
      res_valid <= 1'b0;
    end else begin
      res_valid <= 1'b0;
      if (mac_start) begin
        busy  <= 1'b1;
        k_cnt <= '0;
      end else if (busy) begin
        k_cnt <= k_cnt + 1'b1;
        if (k_cnt == K_LAST) begin
          busy      <= 1'b0;
          res_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < ELEMS; i++) begin
      if (mac_start) acc[i] <= '0;
      else if (busy) acc[i] <= acc[i] + term[i];
    end
  end

  always_comb begin
    for (int i = 0; i < ELEMS; i++) begin
      res[i * `RES_WIDTH +: `RES_WIDTH] = acc[i];
    end
  end

endmodule

`default_nettype wire

// ==== src/gemm_ctrl.sv ====
// job controller of the gemm core
// orders load, compute and drain, and drives the ap_* kernel handshake
`timescale 1ns/1ps
`default_nettype none

module gemm_ctrl (
  input  wire  ap_clk,
  input  wire  areset,
  input  wire  ap_start,
  input  wire  write_result,
  input  wire  a_full,
  input  wire  b_full,
  input  wire  res_valid,
  input  wire  drain_done,
  output logic load_en,
  output logic clear,
  output logic mac_start,
  output logic drain_en,
  output logic ap_idle,
  output logic ap_done,
  output logic ap_ready
);
  import gemm_pkg::*;

  ctrl_state_t state;
  logic        start_q;
  logic        start_pulse;
  logic        wr_q;

  // rising edge of ap_start, ignored unless idle
  assign start_pulse = ap_start & ~start_q;

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      state     <= IDLE;
      start_q   <= 1'b0;
      wr_q      <= 1'b0;
      mac_start <= 1'b0;
    end else begin
      start_q   <= ap_start;
      mac_start <= 1'b0;
      case (state)
        IDLE: begin
          if (start_pulse) begin
            state <= LOAD;
            wr_q  <= write_result;
          end
        end
        LOAD: begin
          if (a_full && b_full) begin
            state     <= COMPUTE;
            mac_start <= 1'b1;
          end
        end
        // without write_result the job ends right after the compute
        COMPUTE: if (res_valid) state <= wr_q ? DRAIN : DONE;
        DRAIN:   if (drain_done) state <= DONE;
        default: state <= IDLE;
      endcase
    end
  end

  assign load_en  = (state == LOAD);
  assign drain_en = (state == COMPUTE) && wr_q;
  assign clear    = (state == DONE);
  assign ap_done  = (state == DONE);
  assign ap_ready = ap_done;
  assign ap_idle  = (state == IDLE) || (state == DONE);

endmodule

`default_nettype wire

// ==== src/result_drain.sv ====
// holds the result tile and sends it out one element per valid/ready transfer
// elements leave in order 0 to M*N-1, drain_done marks the last one
`timescale 1ns/1ps
`default_nettype none

`include "gemm_defines.svh"

module result_drain (
  input  wire                      ap_clk,
  input  wire                      areset,
  input  wire                      drain_en,
  input  wire                      res_valid,
  input  wire gemm_pkg::res_tile_t res,
  input  wire                      out_ready,
  output logic                     out_valid,
  output gemm_pkg::res_t           out_data,
  output logic                     drain_done
);
  import gemm_pkg::*;

  localparam int               ELEMS    = `GEMM_M * `GEMM_N;
  localparam int               IDX_W    = $clog2(ELEMS);
  localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(ELEMS - 1);

  res_tile_t        hold;
  logic [IDX_W-1:0] idx;
  logic             capture;
  logic             xfer;

  assign capture    = drain_en && res_valid;
  assign xfer       = out_valid && out_ready;
  assign drain_done = xfer && (idx == IDX_LAST);

  // word stays put until it transfers
  assign out_data = hold[idx * `RES_WIDTH +: `RES_WIDTH];

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      out_valid <= 1'b0;
      idx       <= '0;
    end else if (capture) begin
      out_valid <= 1'b1;
      idx       <= '0;
    end else if (xfer) begin
      if (idx == IDX_LAST) begin
        out_valid <= 1'b0;
      end else begin
        idx <= idx + 1'b1;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (capture) begin
      hold <= res;
    end
  end

endmodule

`default_nettype wire

// ==== src/w4a8_gemm_top.sv ====
// top level of the w4a8 gemm core
// two four-phase tile inputs, one valid/ready result output, ap_* job control
`timescale 1ns/1ps
`default_nettype none

`include "gemm_defines.svh"

module w4a8_gemm_top (
  input  wire                  ap_clk,
  input  wire                  areset,
  input  wire                  ap_start,
  input  wire                  write_result,
  input  wire                  a_req,
  input  wire gemm_pkg::beat_t a_data,
  input  wire                  b_req,
  input  wire gemm_pkg::beat_t b_data,
  input  wire                  out_ready,
  output wire                  ap_idle,
  output wire                  ap_done,
  output wire                  ap_ready,
  output wire                  a_ack,
  output wire                  b_ack,
  output wire                  out_valid,
  output wire gemm_pkg::res_t  out_data
);
  import gemm_pkg::*;

  logic      load_en;
  logic      clear;
  logic      mac_start;
  logic      drain_en;
  logic      a_full;
  logic      b_full;
  logic      res_valid;
  logic      drain_done;
  a_tile_t   a_tile;
  b_tile_t   b_tile;
  operand_t  operands;
  res_tile_t res_tile;

  assign operands.a = a_tile;
  assign operands.b = b_tile;

  //////////////////////
  // control
  //////////////////////
  gemm_ctrl ctrl0 (
    .ap_clk       (ap_clk),
    .areset       (areset),
    .ap_start     (ap_start),
    .write_result (write_result),
    .a_full       (a_full),
    .b_full       (b_full),
    .res_valid    (res_valid),
    .drain_done   (drain_done),
    .load_en      (load_en),
    .clear        (clear),
    .mac_start    (mac_start),
    .drain_en     (drain_en),
    .ap_idle      (ap_idle),
    .ap_done      (ap_done),
    .ap_ready     (ap_ready)
  );

  //////////////////////
  // input side
  //////////////////////
  tile_loader #(.BEATS(`A_BEATS)) a_loader (
    .ap_clk  (ap_clk),
    .areset  (areset),
    .load_en (load_en),
    .clear   (clear),
    .req     (a_req),
    .data    (a_data),
    .ack     (a_ack),
    .full    (a_full),
    .tile    (a_tile)
  );

  tile_loader #(.BEATS(`B_BEATS)) b_loader (
    .ap_clk  (ap_clk),
    .areset  (areset),
    .load_en (load_en),
    .clear   (clear),
    .req     (b_req),
    .data    (b_data),
    .ack     (b_ack),
    .full    (b_full),
    .tile    (b_tile)
  );

  //////////////////////
  // compute and output
  //////////////////////
  tile_mac mac0 (
    .ap_clk    (ap_clk),
    .areset    (areset),
    .mac_start (mac_start),
    .operands  (operands),
    .res_valid (res_valid),
    .res       (res_tile)
  );

  result_drain drain0 (
    .ap_clk     (ap_clk),
    .areset     (areset),
    .drain_en   (drain_en),
    .res_valid  (res_valid),
    .res        (res_tile),
    .out_ready  (out_ready),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .drain_done (drain_done)
  );

endmodule

`default_nettype wire

// ==== tests/gemm_sva.sv ====
// handshake assertions for the gemm top level
// attached to every w4a8_gemm_top instance by the bind at the end of this file
`timescale 1ns/1ps
`default_nettype none

module gemm_sva (
  input wire                 ap_clk,
  input wire                 areset,
  input wire                 a_req,
  input wire                 a_ack,
  input wire                 b_req,
  input wire                 b_ack,
  input wire                 out_valid,
  input wire                 out_ready,
  input wire gemm_pkg::res_t out_data,
  input wire                 ap_done
);

  //////////////////////
  // four-phase ordering
  //////////////////////
  a_ack_rise: assert property (@(posedge ap_clk) disable iff (areset)
    $rose(a_ack) |-> $past(a_req))
    else $error("a_ack rose while a_req was low");

  a_ack_fall: assert property (@(posedge ap_clk) disable iff (areset)
    $fell(a_ack) |-> !$past(a_req))
    else $error("a_ack fell while a_req was still high");

  b_ack_rise: assert property (@(posedge ap_clk) disable iff (areset)
    $rose(b_ack) |-> $past(b_req))
    else $error("b_ack rose while b_req was low");

  b_ack_fall: assert property (@(posedge ap_clk) disable iff (areset)
    $fell(b_ack) |-> !$past(b_req))
    else $error("b_ack fell while b_req was still high");

  // held word under back-pressure
  out_hold: assert property (@(posedge ap_clk) disable iff (areset)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else $error("out_data changed or out_valid dropped before transfer");

  //////////////////////
  // job handshake
  //////////////////////
  done_pulse: assert property (@(posedge ap_clk) disable iff (areset)
    ap_done |=> !ap_done)
    else $error("ap_done held high for more than one cycle");

endmodule

bind w4a8_gemm_top gemm_sva sva0 (
  .ap_clk    (ap_clk),
  .areset    (areset),
  .a_req     (a_req),
  .a_ack     (a_ack),
  .b_req     (b_req),
  .b_ack     (b_ack),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_data  (out_data),
  .ap_done   (ap_done)
);

`default_nettype wire

// ==== tests/tb_gemm.sv ====
// testbench of the w4a8 gemm core: random jobs over both input channels
// results are checked against a signed integer model of C = A * B^T
`timescale 1ns/1ps
`default_nettype none

`include "gemm_defines.svh"

module tb_gemm;
  import gemm_pkg::*;

  localparam int NUM_JOBS       = 30;
  localparam int TIMEOUT_CYCLES = NUM_JOBS * 200;
  localparam int ELEMS          = `GEMM_M * `GEMM_N;

  logic  ap_clk;
  logic  areset;
  logic  ap_start;
  logic  write_result;
  logic  a_req;
  beat_t a_data;
  logic  b_req;
  beat_t b_data;
  logic  out_ready;
  logic  ap_idle;
  logic  ap_done;
  logic  ap_ready;
  logic  a_ack;
  logic  b_ack;
  logic  out_valid;
  res_t  out_data;

  // scoreboard and per-job bookkeeping
  res_t  exp_q[$];
  res_t  exp_w;
  string test_name = "reset";
  logic  job_wr = 1'b0;
  int    mismatch_cnt = 0;
  int    failure_cnt = 0;
  int    cycle_cnt = 0;
  int    a_rise_cnt = 0;
  int    b_rise_cnt = 0;
  int    done_cnt = 0;
  int    xfer_cnt = 0;
  int    a_base = 0;
  int    b_base = 0;
  int    done_base = 0;
  int    xfer_base = 0;
  logic  prev_a_req = 1'b0;
  logic  prev_a_ack = 1'b0;
  logic  prev_b_req = 1'b0;
  logic  prev_b_ack = 1'b0;
  logic  prev_hold = 1'b0;
  res_t  prev_data = '0;

  w4a8_gemm_top dut0 (
    .ap_clk       (ap_clk),
    .areset       (areset),
    .ap_start     (ap_start),
    .write_result (write_result),
    .a_req        (a_req),
    .a_data       (a_data),
    .b_req        (b_req),
    .b_data       (b_data),
    .out_ready    (out_ready),
    .ap_idle      (ap_idle),
    .ap_done      (ap_done),
    .ap_ready     (ap_ready),
    .a_ack        (a_ack),
    .b_ack        (b_ack),
    .out_valid    (out_valid),
    .out_data     (out_data)
  );

  initial begin
    ap_clk = 1'b0;
    forever #4 ap_clk = ~ap_clk;
  end

  task automatic log_mismatch(input string test, input int expected, input int actual);
    mismatch_cnt++;
    $display("MISMATCH %s: expected %0d, actual %0d", test, expected, actual);
  endtask

  task automatic log_failure(input string what);
    failure_cnt++;
    $display("ERROR: %s", what);
  endtask

  task automatic finish_run();
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, failure_cnt);
    if (mismatch_cnt == 0 && failure_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  function automatic logic ack_of(input int ch);
    return (ch == 0) ? a_ack : b_ack;
  endfunction

  // one four-phase beat on channel 0 (A) or 1 (B), random idle gap first
  task automatic send_beat(input int ch, input beat_t beat);
    repeat ($urandom_range(0, 3)) @(posedge ap_clk);
    @(posedge ap_clk);
    if (ch == 0) begin
      a_data <= beat;
      a_req  <= 1'b1;
    end else begin
      b_data <= beat;
      b_req  <= 1'b1;
    end
    do @(negedge ap_clk); while (!ack_of(ch));
    @(posedge ap_clk);
    if (ch == 0) a_req <= 1'b0;
    else b_req <= 1'b0;
    do @(negedge ap_clk); while (ack_of(ch));
  endtask

  task automatic run_job(input int j);
    int    a_val [`GEMM_M][`GEMM_K];
    int    b_val [`GEMM_N][`GEMM_K];
    beat_t a_beats [`A_BEATS];
    beat_t b_beats [`B_BEATS];
    int    sum;
    int    bit_idx;
    logic  wr;
    // jobs 0 and 1 always drain, job 2 never does
    wr = (j == 2) ? 1'b0 : (j < 2) ? 1'b1 : ($urandom_range(0, 3) != 0);
    // first two jobs sit at the signed extremes
    for (int m = 0; m < `GEMM_M; m++)
      for (int k = 0; k < `GEMM_K; k++)
        a_val[m][k] = (j == 0) ? -128 : (j == 1) ? 127 : int'($urandom_range(0, 255)) - 128;
    for (int n = 0; n < `GEMM_N; n++)
      for (int k = 0; k < `GEMM_K; k++)
        b_val[n][k] = (j < 2) ? -8 : int'($urandom_range(0, 15)) - 8;
    a_beats = '{default: '0};
    b_beats = '{default: '0};
    for (int m = 0; m < `GEMM_M; m++) begin
      for (int k = 0; k < `GEMM_K; k++) begin
        bit_idx = (m * `GEMM_K + k) * `A_WIDTH;
        a_beats[bit_idx / `BEAT_WIDTH][bit_idx % `BEAT_WIDTH +: `A_WIDTH] =
          `A_WIDTH'(a_val[m][k]);
      end
    end
    for (int n = 0; n < `GEMM_N; n++) begin
      for (int k = 0; k < `GEMM_K; k++) begin
        bit_idx = (n * `GEMM_K + k) * `B_WIDTH;
        b_beats[bit_idx / `BEAT_WIDTH][bit_idx % `BEAT_WIDTH +: `B_WIDTH] =
          `B_WIDTH'(b_val[n][k]);
      end
    end
    // reference model, element order m*N+n
    for (int m = 0; m < `GEMM_M; m++) begin
      for (int n = 0; n < `GEMM_N; n++) begin
        sum = 0;
        for (int k = 0; k < `GEMM_K; k++) sum += a_val[m][k] * b_val[n][k];
        if (wr) exp_q.push_back(res_t'(sum));
      end
    end

    @(posedge ap_clk);
    test_name = $sformatf("job%0d", j);
    job_wr    = wr;
    a_base    = a_rise_cnt;
    b_base    = b_rise_cnt;
    done_base = done_cnt;
    xfer_base = xfer_cnt;
    ap_start     <= 1'b1;
    write_result <= wr;
    @(negedge ap_clk);
    @(negedge ap_clk);
    assert (!ap_idle) else log_failure($sformatf("%s: ap_idle did not fall", test_name));
    @(posedge ap_clk);
    ap_start <= 1'b0;
    fork
      for (int i = 0; i < `A_BEATS; i++) send_beat(0, a_beats[i]);
      begin
        for (int i = 0; i < `B_BEATS; i++) send_beat(1, b_beats[i]);
        // one more request once B is full, it must stay unacknowledged
        @(posedge ap_clk);
        b_req <= 1'b1;
      end
    join
    @(posedge ap_clk);
    b_req <= 1'b0;

    do @(negedge ap_clk); while (!ap_done);
    assert (ap_idle) else log_failure($sformatf("%s: ap_idle low with ap_done", test_name));
    @(negedge ap_clk);
    assert (done_cnt - done_base == 1)
      else log_mismatch({test_name, " done pulses"}, 1, done_cnt - done_base);
    assert (a_rise_cnt - a_base == `A_BEATS)
      else log_mismatch({test_name, " a acks"}, `A_BEATS, a_rise_cnt - a_base);
    assert (b_rise_cnt - b_base == `B_BEATS)
      else log_mismatch({test_name, " b acks"}, `B_BEATS, b_rise_cnt - b_base);
    assert (xfer_cnt - xfer_base == (wr ? ELEMS : 0))
      else log_mismatch({test_name, " word count"}, wr ? ELEMS : 0, xfer_cnt - xfer_base);
    exp_q.delete();
  endtask

  //////////////////////
  // monitor, sampled on the falling edge
  //////////////////////
  always @(negedge ap_clk) begin
    if (!areset) begin
      if (a_ack && !prev_a_ack) begin
        assert (prev_a_req) else log_failure("a_ack rose without a_req");
        assert (a_rise_cnt - a_base < `A_BEATS) else log_failure("a_ack rose after A tile full");
        a_rise_cnt++;
      end
      if (!a_ack && prev_a_ack) assert (!prev_a_req) else log_failure("a_ack fell with a_req high");
      if (b_ack && !prev_b_ack) begin
        assert (prev_b_req) else log_failure("b_ack rose without b_req");
        assert (b_rise_cnt - b_base < `B_BEATS) else log_failure("b_ack rose after B tile full");
        b_rise_cnt++;
      end
      if (!b_ack && prev_b_ack) assert (!prev_b_req) else log_failure("b_ack fell with b_req high");
      if (prev_hold) begin
        assert (out_valid) else log_failure("out_valid dropped before its transfer");
        assert (out_data == prev_data)
          else log_mismatch({test_name, " held word"}, prev_data, out_data);
      end
      assert (!(out_valid && !job_wr)) else log_failure("out_valid in a job without write_result");
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          log_failure("output word with no expected result pending");
        end else begin
          exp_w = exp_q.pop_front();
          assert (out_data == exp_w)
            else log_mismatch($sformatf("%s word %0d", test_name, xfer_cnt - xfer_base),
                              exp_w, out_data);
        end
        xfer_cnt++;
      end
      assert (ap_ready == ap_done) else log_failure("ap_ready differs from ap_done");
      if (ap_done) done_cnt++;
    end
    prev_a_req = a_req;
    prev_a_ack = a_ack;
    prev_b_req = b_req;
    prev_b_ack = b_ack;
    prev_hold  = out_valid && !out_ready;
    prev_data  = out_data;
  end

  // random back-pressure
  always @(posedge ap_clk) begin
    if (areset) out_ready <= 1'b0;
    else out_ready <= ($urandom_range(0, 3) != 0);
  end

  always @(posedge ap_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      log_failure("timeout, the jobs did not finish within the cycle limit");
      finish_run();
    end
  end

  initial begin
    void'($urandom(5));
    areset       = 1'b1;
    ap_start     = 1'b0;
    write_result = 1'b0;
    a_req        = 1'b0;
    a_data       = '0;
    b_req        = 1'b0;
    b_data       = '0;
    out_ready    = 1'b0;
    repeat (2) @(posedge ap_clk);
    areset <= 1'b0;
    @(negedge ap_clk);
    assert (ap_idle) else log_failure("ap_idle low after reset");
    assert (!ap_done && !ap_ready) else log_failure("ap_done or ap_ready high after reset");
    assert (!a_ack && !b_ack) else log_failure("ack high after reset");
    assert (!out_valid) else log_failure("out_valid high after reset");
    for (int j = 0; j < NUM_JOBS; j++) run_job(j);
    finish_run();
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+common
common/gemm_pkg.sv
loader/tile_loader.sv
core/tile_mac.sv
src/gemm_ctrl.sv
src/result_drain.sv
src/w4a8_gemm_top.sv
tests/gemm_sva.sv
tests/tb_gemm.sv
